// File: lc3b_perf_pkg.sv
// LC-3b word and opcode types, counter types, event and request structs, counter address map
package lc3b_perf_pkg;

  // Machine word, also used for addresses
  typedef logic [15:0] lc3b_word;

  // LC-3b opcode field encodings
  typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
  } lc3b_opcode;

  localparam int PERF_NUM_COUNTERS = 9;

  typedef logic [15:0] perf_count_t;
  // 0 is no counter, 1..9 select counters 0..8
  typedef logic [3:0] perf_sel_t;
  typedef logic [PERF_NUM_COUNTERS-1:0] perf_clear_t;

  localparam perf_count_t PERF_COUNT_MAX = 16'hFFFF;

  // Counter address map, one even word per counter
  localparam lc3b_word PERF_ADDR_L2_HIT       = 16'hFFF0;
  localparam lc3b_word PERF_ADDR_L2_MISS      = 16'hFFEE;
  localparam lc3b_word PERF_ADDR_DL1_HIT      = 16'hFFEC;
  localparam lc3b_word PERF_ADDR_DL1_MISS     = 16'hFFEA;
  localparam lc3b_word PERF_ADDR_IL1_HIT      = 16'hFFE8;
  localparam lc3b_word PERF_ADDR_IL1_MISS     = 16'hFFE6;
  localparam lc3b_word PERF_ADDR_BR_PREDICT   = 16'hFFE4;
  localparam lc3b_word PERF_ADDR_BR_MISPREDICT = 16'hFFE2;
  localparam lc3b_word PERF_ADDR_STALL        = 16'hFFE0;

  // Per-cycle event strobes, in counter order
  typedef struct packed {
    logic l2_hit;
    logic l2_miss;
    logic dl1_hit;
    logic dl1_miss;
    logic il1_hit;
    logic il1_miss;
    logic br_predict;
    logic br_mispredict;
    logic stall;
  } perf_events_t;

  // Registered request passed to the counter bank and read stage
  typedef struct packed {
    logic        rd;
    perf_clear_t clear;
    perf_sel_t   sel;
  } perf_req_t;

  typedef perf_count_t [PERF_NUM_COUNTERS-1:0] perf_count_vec_t;

endpackage

// File: address_decode.sv
// Address decode: counter address and opcode to counter select and one-hot clear lines
`timescale 1ns/1ps

module address_decode (
  input  lc3b_perf_pkg::lc3b_word    mem_address,
  input  lc3b_perf_pkg::lc3b_opcode  opcode,
  output lc3b_perf_pkg::perf_sel_t   sel,
  output lc3b_perf_pkg::perf_clear_t clear
);

  logic is_store;

  // Only word stores clear a counter
  assign is_store = (opcode == lc3b_perf_pkg::op_str) ||
                    (opcode == lc3b_perf_pkg::op_sti);

  always_comb begin
    case (mem_address)
      // L2 hits
      lc3b_perf_pkg::PERF_ADDR_L2_HIT: begin
        sel = 4'd1;
      end
      // L2 misses
      lc3b_perf_pkg::PERF_ADDR_L2_MISS: begin
        sel = 4'd2;
      end
      lc3b_perf_pkg::PERF_ADDR_DL1_HIT: begin
        sel = 4'd3;
      end
      lc3b_perf_pkg::PERF_ADDR_DL1_MISS: begin
        sel = 4'd4;
      end
      lc3b_perf_pkg::PERF_ADDR_IL1_HIT: begin
        sel = 4'd5;
      end
      lc3b_perf_pkg::PERF_ADDR_IL1_MISS: begin
        sel = 4'd6;
      end
      // Branch predictor
      lc3b_perf_pkg::PERF_ADDR_BR_PREDICT: begin
        sel = 4'd7;
      end
      lc3b_perf_pkg::PERF_ADDR_BR_MISPREDICT: begin
        sel = 4'd8;
      end
      // Cycles spent stalled
      lc3b_perf_pkg::PERF_ADDR_STALL: begin
        sel = 4'd9;
      end
      default: begin
        sel = 4'd0;
      end
    endcase
  end

  // Clear line i follows select code i+1
  always_comb begin
    for (int i = 0; i < lc3b_perf_pkg::PERF_NUM_COUNTERS; i++) begin
      clear[i] = is_store && (sel == lc3b_perf_pkg::perf_sel_t'(i + 1));
    end
  end

endmodule : address_decode

// File: perf_request_stage.sv
// Request stage: qualifies memory strobes with the decoded counter address and registers them
`timescale 1ns/1ps

module perf_request_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  lc3b_perf_pkg::lc3b_word   mem_address,
  input  lc3b_perf_pkg::lc3b_opcode opcode,
  output lc3b_perf_pkg::perf_req_t  req
);

  lc3b_perf_pkg::perf_sel_t   dec_sel;
  lc3b_perf_pkg::perf_clear_t dec_clear;
  lc3b_perf_pkg::perf_req_t   req_next;

  address_decode address_decode_i (
    .mem_address (mem_address),
    .opcode      (opcode),
    .sel         (dec_sel),
    .clear       (dec_clear)
  );

  always_comb begin
    req_next = '0;
    // Select only meaningful while a strobe is up
    if (mem_read || mem_write) begin
      req_next.sel = dec_sel;
    end
    req_next.rd = mem_read && (dec_sel != '0);
    // Store opcode alone is not enough, the write strobe must be up
    if (mem_write) begin
      req_next.clear = dec_clear;
    end
  end

  // One cycle of req per sampled request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req <= '0;
    end else begin
      req <= req_next;
    end
  end

  // Memory stage never reads and writes in the same cycle
  a_no_read_and_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write)
  ) else $error("mem_read and mem_write high together");

endmodule : perf_request_stage

// File: perf_counter_bank.sv
// Counter bank: nine saturating event counters with store-driven clear
`timescale 1ns/1ps

module perf_counter_bank (
  input  logic                           clk,
  input  logic                           rst_n,
  input  lc3b_perf_pkg::perf_events_t    events,
  input  lc3b_perf_pkg::perf_req_t       req,
  output lc3b_perf_pkg::perf_count_vec_t counts
);

  // Event strobes indexed by counter number
  logic [lc3b_perf_pkg::PERF_NUM_COUNTERS-1:0] ev;

  assign ev = {
    events.stall,
    events.br_mispredict,
    events.br_predict,
    events.il1_miss,
    events.il1_hit,
    events.dl1_miss,
    events.dl1_hit,
    events.l2_miss,
    events.l2_hit
  };

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counts <= '0;
    end else begin
      for (int i = 0; i < lc3b_perf_pkg::PERF_NUM_COUNTERS; i++) begin
        // Clear wins over an event in the same cycle
        if (req.clear[i]) begin
          counts[i] <= '0;
        end else if (ev[i] && (counts[i] != lc3b_perf_pkg::PERF_COUNT_MAX)) begin
          counts[i] <= counts[i] + 16'd1;
        end
      end
    end
  end

  // At most one counter cleared per request
  a_clear_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(req.clear)
  ) else $error("more than one counter clear line set");

  for (genvar g = 0; g < lc3b_perf_pkg::PERF_NUM_COUNTERS; g++) begin : g_check
    // Cleared counter reads zero next cycle even with an event present
    a_clear_zero : assert property (
      @(posedge clk) disable iff (!rst_n)
      req.clear[g] |=> (counts[g] == '0)
    ) else $error("counter %0d not zero after clear", g);

    // Counters only move down through a clear
    a_monotonic : assert property (
      @(posedge clk) disable iff (!rst_n)
      !req.clear[g] |=> (counts[g] >= $past(counts[g]))
    ) else $error("counter %0d decreased without clear", g);
  end

endmodule : perf_counter_bank

// File: perf_read_stage.sv
// Read stage: counter select mux with registered read data and hit flag
`timescale 1ns/1ps

module perf_read_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  lc3b_perf_pkg::perf_req_t       req,
  input  lc3b_perf_pkg::perf_count_vec_t counts,
  output logic                           perf_hit,
  output lc3b_perf_pkg::perf_count_t     perf_rdata
);

  lc3b_perf_pkg::perf_count_t sel_count;

  // Select code i+1 names counter i
  always_comb begin
    sel_count = '0;
    for (int i = 0; i < lc3b_perf_pkg::PERF_NUM_COUNTERS; i++) begin
      if (req.sel == lc3b_perf_pkg::perf_sel_t'(i + 1)) begin
        sel_count = counts[i];
      end
    end
  end

  // Counts sampled here are the values before this edge's update
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      perf_hit   <= 1'b0;
      perf_rdata <= '0;
    end else if (req.rd) begin
      perf_hit   <= 1'b1;
      perf_rdata <= sel_count;
    end else begin
      // Data forced to zero so the memory stage can OR it in
      perf_hit   <= 1'b0;
      perf_rdata <= '0;
    end
  end

  // Request stage only raises rd on a decoded counter address
  a_rd_has_sel : assert property (
    @(posedge clk) disable iff (!rst_n)
    req.rd |-> (req.sel != '0)
  ) else $error("counter read with no counter selected");

endmodule : perf_read_stage

// File: perf_counters.sv
// Performance counter top level: request stage, counter bank and read stage
`timescale 1ns/1ps

module perf_counters (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        mem_read,
  input  logic                        mem_write,
  input  lc3b_perf_pkg::lc3b_word     mem_address,
  input  lc3b_perf_pkg::lc3b_opcode   opcode,
  input  lc3b_perf_pkg::perf_events_t events,
  output logic                        perf_hit,
  output lc3b_perf_pkg::perf_count_t  perf_rdata
);

  lc3b_perf_pkg::perf_req_t       req;
  lc3b_perf_pkg::perf_count_vec_t counts;

  // Decode and register the memory stage request
  perf_request_stage perf_request_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_address (mem_address),
    .opcode      (opcode),
    .req         (req)
  );

  perf_counter_bank perf_counter_bank_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .events (events),
    .req    (req),
    .counts (counts)
  );

  // Data back to the memory stage two cycles after the request
  perf_read_stage perf_read_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .counts     (counts),
    .perf_hit   (perf_hit),
    .perf_rdata (perf_rdata)
  );

endmodule : perf_counters

// File: tb_perf_counters.sv
// Testbench for perf_counters: clock, reset, stimulus, reference model, assertions, watchdog
`timescale 1ns/1ps

module tb_perf_counters;

  localparam int CLK_PERIOD       = 100;
  // Test lengths in cycles, drain included
  localparam int LEN_RESET        = 6;
  localparam int LEN_COUNTING     = 230;
  localparam int LEN_CLEAR        = 40;
  localparam int LEN_NO_STORE     = 30;
  localparam int LEN_MISS         = 30;
  localparam int LEN_SATURATE     = 66020;
  localparam int LEN_BACK_TO_BACK = 20;
  localparam int WATCHDOG_CYCLES  = LEN_RESET + LEN_COUNTING + LEN_CLEAR + LEN_NO_STORE +
                                    LEN_MISS + LEN_SATURATE + LEN_BACK_TO_BACK + 500;

  logic                        clk;
  logic                        rst_n;
  logic                        mem_read;
  logic                        mem_write;
  lc3b_perf_pkg::lc3b_word     mem_address;
  lc3b_perf_pkg::lc3b_opcode   opcode;
  lc3b_perf_pkg::perf_events_t events;
  logic                        perf_hit;
  lc3b_perf_pkg::perf_count_t  perf_rdata;

  // Reference model state
  lc3b_perf_pkg::perf_count_t  model_cnt [lc3b_perf_pkg::PERF_NUM_COUNTERS];
  logic                        req_rd_q;
  logic                        req_clr_q;
  int                          req_idx_q;
  logic                        exp_hit;
  lc3b_perf_pkg::perf_count_t  exp_data;

  integer seed = 90;
  string  test_name = "reset";
  int     err_count = 0;
  int     errors_at_start = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  logic   expect_saturated = 1'b0;

  perf_counters perf_counters_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_address (mem_address),
    .opcode      (opcode),
    .events      (events),
    .perf_hit    (perf_hit),
    .perf_rdata  (perf_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Counter number for a mapped address, -1 off the map
  function automatic int counter_index(input lc3b_perf_pkg::lc3b_word addr);
    if (addr[0] || (addr < lc3b_perf_pkg::PERF_ADDR_STALL) ||
        (addr > lc3b_perf_pkg::PERF_ADDR_L2_HIT)) begin
      return -1;
    end
    // Map runs down from l2_hit in steps of two
    return int'(lc3b_perf_pkg::PERF_ADDR_L2_HIT - addr) / 2;
  endfunction

  function automatic lc3b_perf_pkg::lc3b_word counter_address(input int k);
    return lc3b_perf_pkg::PERF_ADDR_L2_HIT - lc3b_perf_pkg::lc3b_word'(2 * k);
  endfunction

  function automatic lc3b_perf_pkg::perf_events_t random_events();
    logic [31:0] r;
    r = $random(seed);
    return r[8:0];
  endfunction

  // Model built from the block's rules, updated on the same edges as the DUT
  always @(posedge clk) begin : reference_model
    int idx;
    idx = counter_index(mem_address);
    if (!rst_n) begin
      for (int k = 0; k < lc3b_perf_pkg::PERF_NUM_COUNTERS; k++) begin
        model_cnt[k] <= '0;
      end
      req_rd_q  <= 1'b0;
      req_clr_q <= 1'b0;
      req_idx_q <= 0;
      exp_hit   <= 1'b0;
      exp_data  <= '0;
    end else begin
      req_rd_q  <= mem_read && (idx >= 0);
      req_clr_q <= mem_write && (idx >= 0) && ((opcode == lc3b_perf_pkg::op_str) ||
                                               (opcode == lc3b_perf_pkg::op_sti));
      req_idx_q <= (idx >= 0) ? idx : 0;
      for (int k = 0; k < lc3b_perf_pkg::PERF_NUM_COUNTERS; k++) begin
        // l2_hit is the struct MSB, stall the LSB
        if (req_clr_q && (req_idx_q == k)) begin
          model_cnt[k] <= '0;
        end else if (events[8 - k] && (model_cnt[k] != 16'hFFFF)) begin
          model_cnt[k] <= model_cnt[k] + 16'd1;
        end
      end
      // Read returns the count before this edge's update
      exp_hit  <= req_rd_q;
      exp_data <= req_rd_q ? model_cnt[req_idx_q] : '0;
    end
  end

  a_read_data : assert property (
    @(posedge clk) disable iff (!rst_n)
    exp_hit |-> (perf_hit && (perf_rdata == exp_data))
  ) else begin
    err_count++;
    $display("Fail %s: expected hit 1 data %h, actual hit %b data %h", test_name,
             $sampled(exp_data), $sampled(perf_hit), $sampled(perf_rdata));
  end

  // No counter read two cycles back
  a_no_hit : assert property (
    @(posedge clk) disable iff (!rst_n)
    !exp_hit |-> (!perf_hit && (perf_rdata == '0))
  ) else begin
    err_count++;
    $display("Fail %s: expected hit 0 data 0000, actual hit %b data %h", test_name,
             $sampled(perf_hit), $sampled(perf_rdata));
  end

  a_saturated : assert property (
    @(posedge clk) disable iff (!rst_n)
    (expect_saturated && exp_hit) |-> (perf_rdata == 16'hFFFF)
  ) else begin
    err_count++;
    $display("Fail %s: expected ffff, actual %h", test_name, $sampled(perf_rdata));
  end

  task automatic drive_cycle(input logic rd, input logic wr,
                             input lc3b_perf_pkg::lc3b_word addr,
                             input lc3b_perf_pkg::lc3b_opcode op,
                             input lc3b_perf_pkg::perf_events_t ev);
    @(negedge clk);
    mem_read    = rd;
    mem_write   = wr;
    mem_address = addr;
    opcode      = op;
    events      = ev;
  endtask

  task automatic idle(input lc3b_perf_pkg::perf_events_t ev);
    drive_cycle(1'b0, 1'b0, 16'h0000, lc3b_perf_pkg::op_add, ev);
  endtask

  task automatic read_counter(input lc3b_perf_pkg::lc3b_word addr,
                              input lc3b_perf_pkg::perf_events_t ev);
    drive_cycle(1'b1, 1'b0, addr, lc3b_perf_pkg::op_ldr, ev);
  endtask

  task automatic write_counter(input lc3b_perf_pkg::lc3b_word addr,
                               input lc3b_perf_pkg::lc3b_opcode op,
                               input lc3b_perf_pkg::perf_events_t ev);
    drive_cycle(1'b0, 1'b1, addr, op, ev);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = err_count;
  endtask

  // Let reads in flight land before the result line
  task automatic finish_test();
    int n;
    repeat (3) idle('0);
    n = err_count - errors_at_start;
    if (n == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %s finished with %0d errors", test_name, n);
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : stimulus
    lc3b_perf_pkg::perf_events_t stall_ev;
    stall_ev       = '0;
    stall_ev.stall = 1'b1;
    rst_n       = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    mem_address = '0;
    opcode      = lc3b_perf_pkg::op_add;
    events      = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("counting");
    repeat (200) idle(random_events());
    for (int k = 0; k < lc3b_perf_pkg::PERF_NUM_COUNTERS; k++) begin
      read_counter(counter_address(k), random_events());
      idle(random_events());
    end
    finish_test();

    start_test("clear_by_store");
    repeat (10) idle(random_events());
    write_counter(lc3b_perf_pkg::PERF_ADDR_DL1_HIT, lc3b_perf_pkg::op_str, random_events());
    repeat (5) idle(random_events());
    read_counter(lc3b_perf_pkg::PERF_ADDR_DL1_HIT, random_events());
    idle(random_events());
    write_counter(lc3b_perf_pkg::PERF_ADDR_IL1_MISS, lc3b_perf_pkg::op_sti, '0);
    // Every event fires in the clear cycle
    idle('1);
    read_counter(lc3b_perf_pkg::PERF_ADDR_IL1_MISS, '0);
    finish_test();

    start_test("write_without_store");
    repeat (5) idle(random_events());
    write_counter(lc3b_perf_pkg::PERF_ADDR_BR_PREDICT, lc3b_perf_pkg::op_stb, '0);
    idle('0);
    read_counter(lc3b_perf_pkg::PERF_ADDR_BR_PREDICT, '0);
    drive_cycle(1'b1, 1'b0, lc3b_perf_pkg::PERF_ADDR_BR_PREDICT, lc3b_perf_pkg::op_str, '0);
    idle('0);
    read_counter(lc3b_perf_pkg::PERF_ADDR_BR_PREDICT, '0);
    finish_test();

    start_test("address_miss");
    read_counter(16'hFFE1, '0);
    read_counter(16'hFFF2, '0);
    read_counter(16'h0000, '0);
    write_counter(16'hFFE1, lc3b_perf_pkg::op_str, '0);
    for (int k = 0; k < lc3b_perf_pkg::PERF_NUM_COUNTERS; k++) begin
      read_counter(counter_address(k), '0);
    end
    finish_test();

    start_test("saturation");
    repeat (66000) idle(stall_ev);
    expect_saturated = 1'b1;
    read_counter(lc3b_perf_pkg::PERF_ADDR_STALL, stall_ev);
    repeat (3) idle(stall_ev);
    read_counter(lc3b_perf_pkg::PERF_ADDR_STALL, stall_ev);
    finish_test();
    expect_saturated = 1'b0;

    start_test("back_to_back");
    for (int k = 0; k < lc3b_perf_pkg::PERF_NUM_COUNTERS; k++) begin
      read_counter(counter_address(k), random_events());
    end
    finish_test();

    $display("Tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_perf_counters

// File: flist.f
lc3b_perf_pkg.sv
address_decode.sv
perf_request_stage.sv
perf_counter_bank.sv
perf_read_stage.sv
perf_counters.sv
tb_perf_counters.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the performance counter testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_perf_counters \
  -o tb_perf_counters_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_perf_counters_sim > sim.log 2>&1 \
  || echo "Simulator returned a non-zero status"

grep -q -F '*** PASSED ***' sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

exit 0
